// File: Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -sv
LINT_FLAGS ?= --lint-only --timing --assert -sv
TOP        ?= tb_pipeline_cpu
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
src/rv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/pipeline_cpu.sv
sim/pipeline_cpu_sva.sv
sim/tb_pipeline_cpu.sv

// File: sim/pipeline_cpu_sva.sv
// pipeline control checker: stall length, reset state and halt behavior of the core
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu_sva (
  input wire clk,
  input wire reset,
  input wire stall,
  input wire redirect,
  input wire halted,
  input wire wb_en
);
  int   stall_errs = 0;
  int   halt_errs  = 0;
  int   reset_errs = 0;
  logic sva_failed;

  assign sva_failed = (stall_errs != 0) || (halt_errs != 0) || (reset_errs != 0);

  // a load-use bubble lasts exactly one cycle
  stall_once: assert property (@(posedge clk) disable iff (reset)
    stall && !halted |=> !stall)
    else begin
      $error("stall held high for two consecutive cycles");
      stall_errs++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> halted && !wb_en)
    else begin
      $error("halted dropped or a write retired after halt");
      halt_errs++;
    end

  reset_quiet: assert property (@(posedge clk)
    $fell(reset) |-> !stall && !redirect && !halted && !wb_en)
    else begin
      $error("control signals active right after reset");
      reset_errs++;
    end

endmodule

bind pipeline_cpu pipeline_cpu_sva i_pipeline_cpu_sva (.*);

`default_nettype wire

// File: sim/tb_pipeline_cpu.sv
// testbench for pipeline_cpu: program load, ISA reference model and retirement checks
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline_cpu;

  localparam int prog_len     = 21;
  localparam int limit_cycles = prog_len * 4 + 20;

  logic        clk          = 1'b0;
  logic        reset        = 1'b1;
  logic        imem_wr_en   = 1'b0;
  logic [31:0] imem_wr_addr = '0;
  logic [31:0] imem_wr_data = '0;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        halted;

  logic [31:0] prog [prog_len];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_val_q [$];
  logic [31:0] lfsr_state = 32'h926a_ad4a;
  logic [1:0]  reset_hist = 2'b00;  // reset level at the last two edges

  pipeline_cpu #(.imem_depth(64), .dmem_depth(64)) i_pipeline_cpu (.*);

  always #20 clk = ~clk;

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  function automatic string mismatch_line(input string sig, input logic [31:0] exp,
                                          input logic [31:0] got);
    return $sformatf("[FAIL] %0t %s expected %h got %h", $time, sig, exp, got);
  endfunction

  // galois lfsr, one step per bit taken
  task automatic draw_imm(output logic [11:0] imm);
    for (int b = 0; b < 12; b++) begin
      imm[b]     = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
  endtask

  function automatic logic [31:0] addi_word(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] alu_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lw_word(input logic [4:0] rd, rs1, input logic [11:0] off);
    return {off, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw_word(input logic [4:0] rs2, rs1, input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                              input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic build_program();
    logic [11:0] r [6];
    foreach (r[k]) draw_imm(r[k]);
    prog[0]  = addi_word(5'd1, 5'd0, r[0]);
    prog[1]  = addi_word(5'd2, 5'd0, r[1]);
    prog[2]  = alu_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);   // add, two forwards
    prog[3]  = alu_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);   // sub
    prog[4]  = alu_word(7'h00, 3'b111, 5'd5, 5'd4, 5'd3);   // and
    prog[5]  = alu_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd2);   // or
    prog[6]  = sw_word(5'd6, 5'd0, 12'd8);
    prog[7]  = lw_word(5'd7, 5'd0, 12'd8);
    prog[8]  = alu_word(7'h00, 3'b000, 5'd8, 5'd7, 5'd1);   // load-use consumer
    prog[9]  = addi_word(5'd9, 5'd8, r[2]);
    prog[10] = branch_word(3'b000, 5'd9, 5'd9, 13'd12);     // beq taken to 13
    prog[11] = addi_word(5'd10, 5'd0, r[3]);                // wrong path
    prog[12] = addi_word(5'd11, 5'd0, r[4]);                // wrong path
    prog[13] = branch_word(3'b001, 5'd1, 5'd1, 13'd8);      // bne not taken
    prog[14] = addi_word(5'd12, 5'd9, r[5]);
    prog[15] = addi_word(5'd17, 5'd0, 12'd10);
    prog[16] = 32'h0000_0073;                               // ecall
    for (int i = 17; i < prog_len; i++) prog[i] = 32'h0000_0013;
  endtask

  // instruction-level model, one instruction per step
  task automatic run_model();
    logic [31:0] xr [32];
    logic [31:0] mem [64];
    logic [31:0] w, a, b, res, imm_i, imm_s, imm_b, addr;
    logic        writes, halt;
    int          pc, next_pc, steps;
    foreach (xr[k]) xr[k] = '0;
    pc    = 0;
    halt  = 1'b0;
    steps = 0;
    while (!halt && steps < 100 && pc / 4 < prog_len) begin
      w       = prog[pc / 4];
      a       = xr[w[19:15]];
      b       = xr[w[24:20]];
      imm_i   = {{20{w[31]}}, w[31:20]};
      imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      writes  = 1'b0;
      next_pc = pc + 4;
      res     = '0;
      case (w[6:0])
        7'b0110011: begin
          writes = 1'b1;
          case (w[14:12])
            3'b111:  res = a & b;
            3'b110:  res = a | b;
            default: res = w[30] ? a - b : a + b;
          endcase
        end
        7'b0010011: begin
          writes = 1'b1;
          res    = a + imm_i;
        end
        7'b0000011: begin
          writes = 1'b1;
          addr   = a + imm_i;
          res    = mem[addr[7:2]];
        end
        7'b0100011: begin
          addr            = a + imm_s;
          mem[addr[7:2]]  = b;
        end
        7'b1100011: if ((a == b) != w[12]) next_pc = pc + int'(imm_b);
        7'b1110011: halt = (xr[17] == 32'd10);
        default: ;
      endcase
      if (writes && w[11:7] != 5'd0) begin
        xr[w[11:7]] = res;
        exp_rd_q.push_back(w[11:7]);
        exp_val_q.push_back(res);
      end
      pc = next_pc;
      steps++;
    end
  endtask

  // outputs sampled at the rising edge before they update
  always @(posedge clk) begin
    if (reset_hist != 2'b00) begin
      assert (!wb_en && !halted)
        else fail_run("wb_en or halted went high during or just after reset");
    end else if (!reset && wb_en && wb_rd != 5'd0) begin
      assert (exp_rd_q.size() != 0)
        else fail_run("register write retired with no write left in the expected list");
      assert (wb_rd == exp_rd_q[0])
        else fail_run(mismatch_line("wb_rd", 32'(exp_rd_q[0]), 32'(wb_rd)));
      assert (wb_data == exp_val_q[0])
        else fail_run(mismatch_line("wb_data", exp_val_q[0], wb_data));
      void'(exp_rd_q.pop_front());
      void'(exp_val_q.pop_front());
    end
    if (halted) begin
      assert (exp_rd_q.size() == 0)
        else fail_run("halted rose while expected writes were still pending");
    end
    assert (!i_pipeline_cpu.i_pipeline_cpu_sva.sva_failed)
      else fail_run("a concurrent check on pipeline control failed");
    reset_hist <= {reset_hist[0], reset};
  end

  initial begin
    @(negedge reset);
    repeat (limit_cycles) @(posedge clk);
    fail_run($sformatf("timeout, no halt within %0d cycles of reset release", limit_cycles));
  end

  initial begin
    build_program();
    run_model();
    // reset spans the program load, then four more cycles
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      imem_wr_en   = 1'b1;
      imem_wr_addr = 32'(i * 4);
      imem_wr_data = prog[i];
    end
    @(negedge clk);
    imem_wr_en = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    wait (halted);
    repeat (4) @(negedge clk);
    if (exp_rd_q.size() == 0 && !i_pipeline_cpu.i_pipeline_cpu_sva.sva_failed) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_run("run ended with expected writes missing");
    end
  end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
// decode stage: control decode, immediates, register file and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                     clk,
  input  wire                     reset,
  input  wire  rv_pkg::instr_t    if_id_instr,
  input  wire  rv_pkg::word_t     if_id_pc,
  input  wire                     stall,
  input  wire                     flush,
  input  wire                     halted,
  input  wire                     wb_en,
  input  wire  rv_pkg::reg_idx_t  wb_rd,
  input  wire  rv_pkg::word_t     wb_data,
  output rv_pkg::alu_op_t         id_ex_alu_op,
  output logic                    id_ex_alu_src,
  output logic                    id_ex_mem_read,
  output logic                    id_ex_mem_write,
  output logic                    id_ex_reg_write,
  output logic                    id_ex_branch,
  output logic                    id_ex_branch_ne,
  output logic                    id_ex_ecall,
  output rv_pkg::reg_idx_t        id_ex_rs1,
  output rv_pkg::reg_idx_t        id_ex_rs2,
  output rv_pkg::reg_idx_t        id_ex_rd,
  output rv_pkg::word_t           id_ex_rs1_data,
  output rv_pkg::word_t           id_ex_rs2_data,
  output rv_pkg::word_t           id_ex_imm,
  output rv_pkg::word_t           id_ex_pc
);
  import rv_pkg::*;

  word_t    regs [32];
  alu_op_t  dec_alu_op;
  logic     dec_alu_src, dec_mem_read, dec_mem_write, dec_reg_write;
  logic     dec_branch, dec_ecall;
  reg_idx_t rs1_idx;
  word_t    dec_imm;
  word_t    rs1_val, rs2_val;

  always_comb begin
    dec_alu_op    = alu_add;
    dec_alu_src   = 1'b0;
    dec_mem_read  = 1'b0;
    dec_mem_write = 1'b0;
    dec_reg_write = 1'b0;
    dec_branch    = 1'b0;
    dec_ecall     = 1'b0;
    rs1_idx       = if_id_instr.r_view.rs1;
    dec_imm       = '0;
    case (if_id_instr.r_view.opcode)
      op: begin
        dec_reg_write = 1'b1;
        case (if_id_instr.r_view.funct3)
          3'b110:  dec_alu_op = alu_or;
          3'b111:  dec_alu_op = alu_and;
          default: dec_alu_op = if_id_instr.r_view.funct7[5] ? alu_sub : alu_add;
        endcase
      end
      op_imm, load: begin
        dec_alu_src   = 1'b1;
        dec_reg_write = 1'b1;
        dec_mem_read  = (if_id_instr.i_view.opcode == load);
        dec_imm       = {{20{if_id_instr.i_view.imm[11]}}, if_id_instr.i_view.imm};
      end
      store: begin
        dec_alu_src   = 1'b1;
        dec_mem_write = 1'b1;
        dec_imm = {{20{if_id_instr.s_view.imm_hi[6]}}, if_id_instr.s_view.imm_hi,
                   if_id_instr.s_view.imm_lo};
      end
      branch: begin
        dec_branch = 1'b1;
        dec_imm = {{19{if_id_instr.b_view.imm_12}}, if_id_instr.b_view.imm_12,
                   if_id_instr.b_view.imm_11, if_id_instr.b_view.imm_10_5,
                   if_id_instr.b_view.imm_4_1, 1'b0};
      end
      system: begin
        // ecall reads a7 and carries the halt code through the alu
        dec_ecall   = 1'b1;
        rs1_idx     = halt_arg_reg;
        dec_alu_op  = alu_pass_b;
        dec_alu_src = 1'b1;
        dec_imm     = halt_code;
      end
      default: ;  // unknown opcode behaves as a bubble
    endcase
  end

  // register file, written at the edge, x0 stays zero
  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // same-cycle writeback bypass
  assign rs1_val = (rs1_idx == '0) ? '0 :
                   (wb_en && wb_rd == rs1_idx) ? wb_data : regs[rs1_idx];
  assign rs2_val = (if_id_instr.r_view.rs2 == '0) ? '0 :
                   (wb_en && wb_rd == if_id_instr.r_view.rs2) ? wb_data :
                   regs[if_id_instr.r_view.rs2];

  always_ff @(posedge clk) begin
    if (reset || (!halted && (stall || flush))) begin
      id_ex_alu_op    <= alu_add;
      id_ex_alu_src   <= 1'b0;
      id_ex_mem_read  <= 1'b0;
      id_ex_mem_write <= 1'b0;
      id_ex_reg_write <= 1'b0;
      id_ex_branch    <= 1'b0;
      id_ex_branch_ne <= 1'b0;
      id_ex_ecall     <= 1'b0;
      id_ex_rs1       <= '0;
      id_ex_rs2       <= '0;
      id_ex_rd        <= '0;
    end else if (!halted) begin
      id_ex_alu_op    <= dec_alu_op;
      id_ex_alu_src   <= dec_alu_src;
      id_ex_mem_read  <= dec_mem_read;
      id_ex_mem_write <= dec_mem_write;
      id_ex_reg_write <= dec_reg_write;
      id_ex_branch    <= dec_branch;
      id_ex_branch_ne <= if_id_instr.b_view.funct3[0];  // bne when set
      id_ex_ecall     <= dec_ecall;
      id_ex_rs1       <= rs1_idx;
      id_ex_rs2       <= if_id_instr.r_view.rs2;
      id_ex_rd        <= if_id_instr.r_view.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (!halted) begin
      id_ex_rs1_data <= rs1_val;
      id_ex_rs2_data <= rs2_val;
      id_ex_imm      <= dec_imm;
      id_ex_pc       <= if_id_pc;
    end
  end

endmodule

`default_nettype wire

// File: src/execute_stage.sv
// execute stage: forwarding muxes, alu, branch and halt resolution, EX/MEM register
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     halted,
  input  wire  rv_pkg::alu_op_t   id_ex_alu_op,
  input  wire                     id_ex_alu_src,
  input  wire                     id_ex_mem_read,
  input  wire                     id_ex_mem_write,
  input  wire                     id_ex_reg_write,
  input  wire                     id_ex_branch,
  input  wire                     id_ex_branch_ne,
  input  wire                     id_ex_ecall,
  input  wire  rv_pkg::reg_idx_t  id_ex_rs1,
  input  wire  rv_pkg::reg_idx_t  id_ex_rs2,
  input  wire  rv_pkg::reg_idx_t  id_ex_rd,
  input  wire  rv_pkg::word_t     id_ex_rs1_data,
  input  wire  rv_pkg::word_t     id_ex_rs2_data,
  input  wire  rv_pkg::word_t     id_ex_imm,
  input  wire  rv_pkg::word_t     id_ex_pc,
  input  wire  rv_pkg::fwd_sel_t  fwd_a,
  input  wire  rv_pkg::fwd_sel_t  fwd_b,
  input  wire  rv_pkg::word_t     wb_data,
  output logic                    redirect,
  output logic                    flush,
  output rv_pkg::word_t           redirect_pc,
  output rv_pkg::word_t           ex_mem_alu_result,
  output rv_pkg::word_t           ex_mem_store_data,
  output rv_pkg::reg_idx_t        ex_mem_rd,
  output logic                    ex_mem_reg_write,
  output logic                    ex_mem_mem_read,
  output logic                    ex_mem_mem_write,
  output logic                    ex_mem_halt
);
  import rv_pkg::*;

  word_t op_a, op_b, alu_b, alu_result;
  logic  taken, ex_halt;

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
    case (sel)
      fwd_ex_mem: return ex_mem_alu_result;
      fwd_mem_wb: return wb_data;
      default:    return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a, id_ex_rs1_data);
  assign op_b  = fwd_mux(fwd_b, id_ex_rs2_data);
  assign alu_b = id_ex_alu_src ? id_ex_imm : op_b;

  always_comb begin
    case (id_ex_alu_op)
      alu_sub:    alu_result = op_a - alu_b;
      alu_and:    alu_result = op_a & alu_b;
      alu_or:     alu_result = op_a | alu_b;
      alu_pass_b: alu_result = alu_b;
      default:    alu_result = op_a + alu_b;
    endcase
  end

  assign taken       = id_ex_branch && ((op_a == op_b) != id_ex_branch_ne);
  assign redirect    = taken;
  assign flush       = taken;  // drops the two younger instructions
  assign redirect_pc = id_ex_pc + id_ex_imm;

  // ecall passes the halt code through the alu, compare against a7
  assign ex_halt = id_ex_ecall && (op_a == alu_result);

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_rd        <= '0;
      ex_mem_reg_write <= 1'b0;
      ex_mem_mem_read  <= 1'b0;
      ex_mem_mem_write <= 1'b0;
      ex_mem_halt      <= 1'b0;
    end else if (!halted) begin
      ex_mem_rd        <= id_ex_rd;
      ex_mem_reg_write <= id_ex_reg_write && id_ex_rd != '0;
      ex_mem_mem_read  <= id_ex_mem_read;
      ex_mem_mem_write <= id_ex_mem_write;
      ex_mem_halt      <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    if (!halted) begin
      ex_mem_alu_result <= alu_result;
      ex_mem_store_data <= op_b;  // forwarded rs2 for sw
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_stage.sv
// fetch stage: program counter, instruction memory and the IF/ID register
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter int imem_depth = 256
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  stall,
  input  wire                  redirect,
  input  wire  rv_pkg::word_t  redirect_pc,
  input  wire                  halted,
  input  wire                  imem_wr_en,
  input  wire  rv_pkg::word_t  imem_wr_addr,  // byte address
  input  wire  rv_pkg::word_t  imem_wr_data,
  output rv_pkg::instr_t       if_id_instr,
  output rv_pkg::word_t        if_id_pc
);
  import rv_pkg::*;

  localparam int addr_w = $clog2(imem_depth);

  word_t imem [imem_depth];
  word_t pc;
  word_t fetch_word;

  // program load, accepted only while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset && imem_wr_en) begin
      imem[imem_wr_addr[addr_w+1:2]] <= imem_wr_data;
    end
  end

  assign fetch_word = imem[pc[addr_w+1:2]];  // async read

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      if_id_instr <= nop_instr;
    end else if (!halted) begin
      if (redirect) begin
        pc          <= redirect_pc;
        if_id_instr <= nop_instr;  // squash the wrong-path fetch
      end else if (!stall) begin
        pc          <= pc + 32'd4;
        if_id_instr <= fetch_word;
      end
    end
  end

  // pc travels with the word, meaningless behind a bubble
  always_ff @(posedge clk) begin
    if (!halted && !stall) begin
      if_id_pc <= pc;
    end
  end

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
// hazard unit: load-use stall detection and operand forwarding selects
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  wire  rv_pkg::instr_t    if_id_instr,
  input  wire  rv_pkg::reg_idx_t  id_ex_rd,
  input  wire                     id_ex_mem_read,
  input  wire  rv_pkg::reg_idx_t  id_ex_rs1,
  input  wire  rv_pkg::reg_idx_t  id_ex_rs2,
  input  wire  rv_pkg::reg_idx_t  ex_mem_rd,
  input  wire                     ex_mem_reg_write,
  input  wire  rv_pkg::reg_idx_t  wb_rd,
  input  wire                     wb_en,
  output logic                    stall,
  output rv_pkg::fwd_sel_t        fwd_a,
  output rv_pkg::fwd_sel_t        fwd_b
);
  import rv_pkg::*;

  reg_idx_t src1;
  logic     uses_rs2;

  // newest producer wins, x0 never forwarded
  function automatic fwd_sel_t pick_fwd(reg_idx_t rs);
    if (rs != '0 && ex_mem_reg_write && ex_mem_rd == rs) return fwd_ex_mem;
    if (rs != '0 && wb_en && wb_rd == rs) return fwd_mem_wb;
    return fwd_none;
  endfunction

  assign src1 = (if_id_instr.r_view.opcode == system) ? halt_arg_reg : if_id_instr.r_view.rs1;
  assign uses_rs2 = if_id_instr.r_view.opcode inside {op, store, branch};

  assign stall = id_ex_mem_read && id_ex_rd != '0 &&
                 (id_ex_rd == src1 || (uses_rs2 && id_ex_rd == if_id_instr.r_view.rs2));

  assign fwd_a = pick_fwd(id_ex_rs1);
  assign fwd_b = pick_fwd(id_ex_rs2);

endmodule

`default_nettype wire

// File: src/mem_wb_stage.sv
// memory and writeback stage: data memory, MEM/WB register and halt flag
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage #(
  parameter int dmem_depth = 256
) (
  input  wire                     clk,
  input  wire                     reset,
  input  wire  rv_pkg::word_t     ex_mem_alu_result,
  input  wire  rv_pkg::word_t     ex_mem_store_data,
  input  wire  rv_pkg::reg_idx_t  ex_mem_rd,
  input  wire                     ex_mem_reg_write,
  input  wire                     ex_mem_mem_read,
  input  wire                     ex_mem_mem_write,
  input  wire                     ex_mem_halt,
  output logic                    wb_en,
  output rv_pkg::reg_idx_t        wb_rd,
  output rv_pkg::word_t           wb_data,
  output logic                    halted
);
  import rv_pkg::*;

  localparam int addr_w = $clog2(dmem_depth);

  word_t dmem [dmem_depth];
  word_t load_data;

  // byte address from the alu, low two bits dropped
  assign load_data = dmem[ex_mem_alu_result[addr_w+1:2]];

  always_ff @(posedge clk) begin
    if (ex_mem_mem_write && !halted) begin
      dmem[ex_mem_alu_result[addr_w+1:2]] <= ex_mem_store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_en  <= 1'b0;
      wb_rd  <= '0;
      halted <= 1'b0;
    end else if (!halted) begin  // sticky until reset
      wb_en  <= ex_mem_reg_write;
      wb_rd  <= ex_mem_rd;
      halted <= ex_mem_halt;
    end
  end

  always_ff @(posedge clk) begin
    if (!halted) begin
      wb_data <= ex_mem_mem_read ? load_data : ex_mem_alu_result;
    end
  end

endmodule

`default_nettype wire

// File: src/pipeline_cpu.sv
// pipeline_cpu: five-stage rv32i subset core with forwarding and load-use stall
`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu #(
  parameter int imem_depth = 256,
  parameter int dmem_depth = 256
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  imem_wr_en,
  input  wire  rv_pkg::word_t  imem_wr_addr,
  input  wire  rv_pkg::word_t  imem_wr_data,
  output logic                 wb_en,
  output rv_pkg::reg_idx_t     wb_rd,
  output rv_pkg::word_t        wb_data,
  output logic                 halted
);
  import rv_pkg::*;

  // hazard and redirect controls
  logic     stall, redirect, flush;
  word_t    redirect_pc;
  fwd_sel_t fwd_a, fwd_b;

  instr_t   if_id_instr;
  word_t    if_id_pc;

  alu_op_t  id_ex_alu_op;
  logic     id_ex_alu_src, id_ex_mem_read, id_ex_mem_write, id_ex_reg_write;
  logic     id_ex_branch, id_ex_branch_ne, id_ex_ecall;
  reg_idx_t id_ex_rs1, id_ex_rs2, id_ex_rd;
  word_t    id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc;

  word_t    ex_mem_alu_result, ex_mem_store_data;
  reg_idx_t ex_mem_rd;
  logic     ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_halt;

  // stage ports share the names of these nets
  fetch_stage #(.imem_depth(imem_depth)) i_fetch_stage (.*);

  decode_stage i_decode_stage (.*);

  hazard_unit i_hazard_unit (.*);

  execute_stage i_execute_stage (.*);

  mem_wb_stage #(.dmem_depth(dmem_depth)) i_mem_wb_stage (.*);

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
// rv32i subset pipeline: shared widths, encodings and instruction formats
`default_nettype none

package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  typedef enum logic [6:0] {
    op     = 7'b0110011,  // add, sub, and, or
    op_imm = 7'b0010011,  // addi
    load   = 7'b0000011,
    store  = 7'b0100011,
    branch = 7'b1100011,  // beq, bne
    system = 7'b1110011   // ecall
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_pass_b
  } alu_op_t;

  // operand source picked in EX
  typedef enum logic [1:0] {
    fwd_none   = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  // branch offset is scattered, bit 0 implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
    s_fmt_t s_view;
    b_fmt_t b_view;
  } instr_t;

  localparam reg_idx_t halt_arg_reg = 5'd17;  // a7
  localparam word_t    halt_code    = 32'd10;
  localparam word_t    nop_instr    = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire
